// File: fb_video.f
design/fb_pkg.sv
design/fb_ifs.sv
design/video_timing.sv
design/pattern_writer.sv
design/display_fetch.sv
design/wb_arbiter.sv
design/frame_ram.sv
design/fb_video_top.sv
bench/fb_video_sva.sv
bench/fb_video_checker.sv
bench/fb_video_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fb_video_tb
FILELIST  ?= fb_video.f
SIM_ARGS  ?= +verilator+error+limit+100000
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/fb_video_tb.sv
`default_nettype none

module fb_video_tb import fb_pkg::*; ();

	localparam int     clk_period   = 100;
	localparam int     drive_delay  = 10;    // After the rising edge
	localparam int     reset_cycles = 4;
	localparam int     last_frame   = 3;
	localparam int     n_pos        = 13;
	localparam int     n_rows       = n_pos * last_frame;
	localparam longint timeout_cycles = longint'(last_frame + 2) * h_total * v_total;

	// Sample positions in raster order, corners and all four edges
	localparam int pos_x [n_pos] = '{0, 7, 639, 7, 8, 15, 327, 0, 639, 100, 0, 319, 639};
	localparam int pos_y [n_pos] = '{0, 0, 0, 7, 8, 15, 100, 240, 240, 333, 479, 479, 479};

	logic   clk_25_2m;
	logic   reset;
	pixel_t hdmi_tx_d;
	logic   hdmi_tx_de;
	logic   hdmi_tx_hs;
	logic   hdmi_tx_vs;
	logic   req;
	int     req_frame;
	int     req_x;
	int     req_y;
	pixel_t req_color;
	logic   done;
	logic   ok;
	int     check_errors;
	int     frames_seen;
	int     row_frame [n_rows];
	int     row_x [n_rows];
	int     row_y [n_rows];
	pixel_t row_color [n_rows];
	int     pass_cnt;
	int     fail_cnt;
	int     sva_errors;

	fb_video_top u_fb_video_top (
		.clk_25_2m  (clk_25_2m),
		.reset      (reset),
		.hdmi_tx_d  (hdmi_tx_d),
		.hdmi_tx_de (hdmi_tx_de),
		.hdmi_tx_hs (hdmi_tx_hs),
		.hdmi_tx_vs (hdmi_tx_vs)
	);

	fb_video_checker u_checker (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.d         (hdmi_tx_d),
		.de        (hdmi_tx_de),
		.hs        (hdmi_tx_hs),
		.vs        (hdmi_tx_vs),
		.req       (req),
		.req_frame (req_frame),
		.req_x     (req_x),
		.req_y     (req_y),
		.req_color (req_color),
		.done      (done),
		.ok        (ok),
		.errors    (check_errors),
		.frames    (frames_seen)
	);

	// ====================
	// Bound assertions
	// ====================
	bind wb_arbiter fb_video_sva u_arb_sva (
		.clk_25_2m    (clk_25_2m),
		.reset        (reset),
		.grant_fetch  (grant_fetch),
		.grant_writer (grant_writer),
		.fetch_cyc    (fetch_bus.cyc),
		.writer_cyc   (writer_bus.cyc),
		.ack          (ram_bus.ack),
		.stb          (ram_bus.stb),
		.de           (1'b0),
		.hs           (1'b1),
		.vs           (1'b1)
	);

	bind video_timing fb_video_sva u_raster_sva (
		.clk_25_2m    (clk_25_2m),
		.reset        (reset),
		.grant_fetch  (1'b0),
		.grant_writer (1'b0),
		.fetch_cyc    (1'b0),
		.writer_cyc   (1'b0),
		.ack          (1'b0),
		.stb          (1'b0),
		.de           (raster.de),
		.hs           (raster.hs),
		.vs           (raster.vs)
	);

	// Frame k shows fill parity k-1, red on even tile sums
	function automatic pixel_t expected_color(input int frame, input int x, input int y);
		int parity;
		int sum;
		parity = (frame - 1) % 2;
		sum    = x / 8 + y / 8 + parity;
		return (sum % 2 == 0) ? color_red : color_blue;
	endfunction

	initial begin
		clk_25_2m = 1'b0;
		forever #(clk_period / 2) clk_25_2m = ~clk_25_2m;
	end

	// Watchdog sized from the last sampled frame
	initial begin
		repeat (timeout_cycles) @(posedge clk_25_2m);
		$display("Timeout: no verdict for frame %0d x %0d y %0d", req_frame, req_x, req_y);
		$display("CHECKS FAILED");
		$finish;
	end

	// ====================
	// Table and stimulus
	// ====================
	initial begin
		reset     = 1'b0;   // Held low from time zero
		req       = 1'b0;
		req_frame = 0;
		req_x     = 0;
		req_y     = 0;
		req_color = '0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		for (int f = 1; f <= last_frame; f++) begin
			for (int p = 0; p < n_pos; p++) begin
				row_frame[(f - 1) * n_pos + p] = f;
				row_x[(f - 1) * n_pos + p]     = pos_x[p];
				row_y[(f - 1) * n_pos + p]     = pos_y[p];
				row_color[(f - 1) * n_pos + p] = expected_color(f, pos_x[p], pos_y[p]);
			end
		end
		repeat (reset_cycles) @(posedge clk_25_2m);
		#drive_delay reset = 1'b1;

		for (int i = 0; i < n_rows; i++) begin
			@(posedge clk_25_2m);
			#drive_delay;
			req_frame = row_frame[i];
			req_x     = row_x[i];
			req_y     = row_y[i];
			req_color = row_color[i];
			req       = 1'b1;
			do @(posedge clk_25_2m); while (!done);   // Checker verdict
			#drive_delay;
			req = 1'b0;
			if (ok) pass_cnt++;
			else fail_cnt++;
			$display("Sample %0d frame %0d x %0d y %0d: %s", i, row_frame[i], row_x[i], row_y[i],
				ok ? "match" : "wrong colour");
			while (done) @(posedge clk_25_2m);
		end

		sva_errors = u_fb_video_top.u_wb_arbiter.u_arb_sva.fail_count +
			u_fb_video_top.u_video_timing.u_raster_sva.fail_count;
		if (frames_seen != last_frame)
			$display("Checker counted %0d vsync pulses instead of %0d", frames_seen, last_frame);
		$display("Summary: %0d of %0d matched, %0d wrong, %0d checker errors, %0d SVA failures",
			pass_cnt, n_rows, fail_cnt, check_errors, sva_errors);
		if (fail_cnt == 0 && check_errors == 0 && sva_errors == 0 && frames_seen == last_frame) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/fb_video_checker.sv
`default_nettype none

module fb_video_checker import fb_pkg::*; (
	input  logic   clk_25_2m,
	input  logic   reset,
	input  pixel_t d,           // DUT video outputs
	input  logic   de,
	input  logic   hs,
	input  logic   vs,
	input  logic   req,         // Sample request from the testbench
	input  int     req_frame,
	input  int     req_x,
	input  int     req_y,
	input  pixel_t req_color,
	output logic   done,        // Verdict ready
	output logic   ok,          // Sample matched
	output int     errors,      // Timing, blanking and block errors
	output int     frames       // vs pulses seen so far
);

	localparam int tile_edge = 1 << tile_shift;

	logic        de_q = 1'b0;   // Previous sample
	logic        hs_q = 1'b1;
	logic        vs_q = 1'b1;
	logic        rst_q = 1'b1;  // Reset seen on the previous sample
	logic        seen_hs = 1'b0;
	logic        seen_vs = 1'b0;
	logic        hit = 1'b0;
	logic        hit_ok = 1'b0;
	int          err_cnt = 0;
	int          frame_cnt = 0;
	int          x = 0;         // Position inside active video
	int          y = 0;
	int          lines = 0;     // Active lines since the last vs
	int          run = 0;       // Length of the current de run
	int          hs_gap = 0;    // Clocks since the last hs fall
	int          hs_low = 0;
	int          vs_low = 0;
	int          hs_falls = 0;  // Lines since the last vs
	logic [12:0] blk;
	pixel_t      blk_first [tiles_per_frame];   // Top-left pixel of each block

	assign done   = hit;
	assign ok     = hit_ok;
	assign errors = err_cnt;
	assign frames = frame_cnt;

	task automatic count_mismatch(input string name, input int expected, input int actual);
		$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
		err_cnt++;
	endtask

	task automatic pixel_mismatch(input string name, input pixel_t expected, input pixel_t actual);
		$display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
		err_cnt++;
	endtask

	// Outputs move on the rising edge, so everything is sampled on the falling one
	always @(negedge clk_25_2m) begin
		// ====================
		// Reset window
		// ====================
		if (!reset || rst_q) begin
			if (de !== 1'b0) count_mismatch("hdmi_tx_de", 0, int'(de));
			if (hs !== 1'b1) count_mismatch("hdmi_tx_hs", 1, int'(hs));
			if (vs !== 1'b1) count_mismatch("hdmi_tx_vs", 1, int'(vs));
			if (d !== '0) pixel_mismatch("hdmi_tx_d", '0, d);
		end
		rst_q = !reset;
		if (reset) begin
			if (!de && d !== '0)
				pixel_mismatch("hdmi_tx_d in blanking", '0, d);   // Black outside de

			// ====================
			// Sync timing
			// ====================
			hs_gap++;
			if (!hs) hs_low++;
			if (hs_q && !hs) begin
				if (seen_hs && hs_gap != h_total)
					count_mismatch("hs line length", h_total, hs_gap);
				seen_hs  = 1'b1;
				hs_gap   = 0;
				hs_falls++;
			end
			if (!hs_q && hs) begin
				if (hs_low != h_sync) count_mismatch("hs low width", h_sync, hs_low);
				hs_low = 0;
			end
			if (!vs) vs_low++;
			if (vs_q && !vs) begin
				if (seen_vs && hs_falls != v_total)
					count_mismatch("lines per frame", v_total, hs_falls);
				if (lines != v_active) count_mismatch("active lines per frame", v_active, lines);
				seen_vs  = 1'b1;
				hs_falls = 0;
				lines    = 0;
				frame_cnt++;   // Next active area belongs to the next frame
			end
			if (!vs_q && vs) begin
				if (vs_low != v_sync * h_total)
					count_mismatch("vs low width", v_sync * h_total, vs_low);
				vs_low = 0;
			end

			// Position follows de runs
			if (de && !de_q) begin
				x = 0;
				y = lines;
			end else if (de) begin
				x++;
			end
			if (de) run++;
			if (!de && de_q) begin
				if (run != h_active) count_mismatch("de run length", h_active, run);
				run = 0;
				lines++;
			end

			// ====================
			// Blocks and samples
			// ====================
			if (de && frame_cnt >= 1 && frame_cnt <= 3 && x < h_active && y < v_active) begin
				blk = 13'((y / tile_edge) * tiles_x + (x / tile_edge));
				if (x % tile_edge == 0 && y % tile_edge == 0)
					blk_first[blk] = d;   // Block reference
				else if (d !== blk_first[blk])
					pixel_mismatch("hdmi_tx_d in 8x8 block", blk_first[blk], d);
			end
			if (req && !hit && de && frame_cnt == req_frame && x == req_x && y == req_y) begin
				hit_ok = (d === req_color);
				if (!hit_ok) pixel_mismatch("hdmi_tx_d", req_color, d);
				hit = 1'b1;
			end
		end
		if (!req) hit = 1'b0;   // Handshake closed
		de_q = de;
		hs_q = hs;
		vs_q = vs;
	end

endmodule

`default_nettype wire

// File: bench/fb_video_sva.sv
`default_nettype none

module fb_video_sva (
	input logic clk_25_2m,
	input logic reset,
	input logic grant_fetch,    // Arbiter grants
	input logic grant_writer,
	input logic fetch_cyc,      // Master cycle requests
	input logic writer_cyc,
	input logic ack,            // Memory side of the arbiter
	input logic stb,
	input logic de,             // Raster decodes
	input logic hs,
	input logic vs
);

	int fail_count = 0;   // Read by the testbench at the end

	// ====================
	// Arbiter
	// ====================
	// A granted master owns the bus until it closes its cycle
	fetch_grant_held: assert property (@(posedge clk_25_2m) disable iff (!reset)
		grant_fetch |=> (grant_fetch || !fetch_cyc))
		else begin
			fail_count++;
			$error("Display fetch lost the bus inside its cycle");
		end

	writer_grant_held: assert property (@(posedge clk_25_2m) disable iff (!reset)
		grant_writer |=> (grant_writer || !writer_cyc))
		else begin
			fail_count++;
			$error("Pattern writer lost the bus inside its cycle");
		end

	// Slave only answers an open strobe
	ack_needs_stb: assert property (@(posedge clk_25_2m) disable iff (!reset)
		ack |-> stb)
		else begin
			fail_count++;
			$error("Memory ack without stb");
		end

	// ====================
	// Raster
	// ====================
	de_outside_sync: assert property (@(posedge clk_25_2m) disable iff (!reset)
		de |-> (hs && vs))
		else begin
			fail_count++;
			$error("Active video during a sync pulse");
		end

endmodule

`default_nettype wire

// File: design/fb_video_top.sv
`default_nettype none

module fb_video_top import fb_pkg::*; (
	input  logic   clk_25_2m,
	input  logic   reset,        // Active low
	output pixel_t hdmi_tx_d,
	output logic   hdmi_tx_de,
	output logic   hdmi_tx_hs,
	output logic   hdmi_tx_vs
);

	logic front_sel;   // Buffer on screen

	raster_if raster ();
	wb_if     writer_bus ();
	wb_if     fetch_bus ();
	wb_if     ram_bus ();

	// ====================
	// Timing and sources
	// ====================
	video_timing u_video_timing (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.raster    (raster)
	);

	pattern_writer u_pattern_writer (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.raster    (raster),
		.bus       (writer_bus),
		.front_sel (front_sel)
	);

	display_fetch u_display_fetch (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.raster    (raster),
		.bus       (fetch_bus),
		.front_sel (front_sel),
		.pix       (hdmi_tx_d),
		.de        (hdmi_tx_de),
		.hs        (hdmi_tx_hs),
		.vs        (hdmi_tx_vs)
	);

	// ====================
	// Shared memory
	// ====================
	wb_arbiter u_wb_arbiter (
		.clk_25_2m  (clk_25_2m),
		.reset      (reset),
		.fetch_bus  (fetch_bus),
		.writer_bus (writer_bus),
		.ram_bus    (ram_bus)
	);

	frame_ram u_frame_ram (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.bus       (ram_bus)
	);

endmodule

`default_nettype wire

// File: design/frame_ram.sv
`default_nettype none

module frame_ram import fb_pkg::*; (
	input  logic clk_25_2m,
	input  logic reset,
	wb_if.slave  bus
);

	pixel_t mem [ram_depth];   // Buffer 0 low half, buffer 1 high half
	pixel_t rd_q;
	logic   ack_q;
	logic   req;

	assign req = bus.cyc && bus.stb && !ack_q;   // New transfer only

	always_ff @(posedge clk_25_2m) begin
		if (!reset)
			ack_q <= 1'b0;
		else
			ack_q <= req;   // Single-clock ack
	end

	always_ff @(posedge clk_25_2m) begin
		if (req && bus.we)
			mem[bus.adr] <= bus.dat_w;
		if (req)
			rd_q <= mem[bus.adr];
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rd_q;

endmodule

`default_nettype wire

// File: design/wb_arbiter.sv
`default_nettype none

module wb_arbiter import fb_pkg::*; (
	input  logic clk_25_2m,
	input  logic reset,
	wb_if.slave  fetch_bus,
	wb_if.slave  writer_bus,
	wb_if.master ram_bus
);

	logic locked;         // A cycle was running last clock
	logic owner_fetch;    // Who had it
	logic hold;           // Owner still in its cycle
	logic grant_fetch;
	logic grant_writer;

	// ====================
	// Grant
	// ====================
	assign hold = locked && (owner_fetch ? fetch_bus.cyc : writer_bus.cyc);

	// Display wins whenever the bus is free
	assign grant_fetch  = hold ? owner_fetch : fetch_bus.cyc;
	assign grant_writer = hold ? ~owner_fetch : (~fetch_bus.cyc & writer_bus.cyc);

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			locked      <= 1'b0;
			owner_fetch <= 1'b0;
		end else begin
			locked      <= ram_bus.cyc;
			owner_fetch <= grant_fetch;
		end
	end

	// ====================
	// Routing
	// ====================
	assign ram_bus.cyc   = (grant_fetch & fetch_bus.cyc) | (grant_writer & writer_bus.cyc);
	assign ram_bus.stb   = grant_fetch ? fetch_bus.stb   : writer_bus.stb;
	assign ram_bus.we    = grant_fetch ? fetch_bus.we    : writer_bus.we;
	assign ram_bus.adr   = grant_fetch ? fetch_bus.adr   : writer_bus.adr;
	assign ram_bus.dat_w = grant_fetch ? fetch_bus.dat_w : writer_bus.dat_w;

	assign fetch_bus.ack    = grant_fetch & ram_bus.ack;
	assign writer_bus.ack   = grant_writer & ram_bus.ack;
	assign fetch_bus.dat_r  = grant_fetch ? ram_bus.dat_r : '0;
	assign writer_bus.dat_r = grant_writer ? ram_bus.dat_r : '0;

endmodule

`default_nettype wire

// File: design/display_fetch.sv
`default_nettype none

module display_fetch import fb_pkg::*; (
	input  logic    clk_25_2m,
	input  logic    reset,
	raster_if.sink  raster,
	wb_if.master    bus,
	input  logic    front_sel,
	output pixel_t  pix,
	output logic    de,
	output logic    hs,
	output logic    vs
);

	coord_t    next_y;       // Line after the current one
	coord_t    tile_x;       // Coming tile column
	coord_t    tile_y;       // Coming tile row
	logic      coming_ok;    // Coming tile is on screen
	logic      adv;          // Tile boundary at the next edge
	tile_idx_t tile_idx;
	wb_addr_t  adr_q;
	logic      cyc_q;
	logic      next_valid;
	pixel_t    cur_word;     // Tile under the raster
	pixel_t    next_word;    // Prefetched tile

	// ====================
	// Coming tile
	// ====================
	always_comb begin
		next_y = (raster.y == coord_t'(v_total - 1)) ? '0 : raster.y + 1'b1;
		if (raster.x < coord_t'(h_active)) begin
			tile_x = (raster.x >> tile_shift) + 1'b1;
			tile_y = raster.y >> tile_shift;
		end else begin
			tile_x = '0;   // Hblank: first tile of next line
			tile_y = next_y >> tile_shift;
		end
		coming_ok = (tile_x < coord_t'(tiles_x)) && (tile_y < coord_t'(tiles_y));
		if (raster.x < coord_t'(h_active))
			adv = coming_ok && (raster.x[tile_shift-1:0] == '1);
		else
			adv = coming_ok && (raster.x == coord_t'(h_total - 1));
	end

	assign tile_idx = tile_idx_t'(tile_y) * tile_idx_t'(tiles_x) + tile_idx_t'(tile_x);

	// ====================
	// Prefetch control
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			cyc_q      <= 1'b0;
			next_valid <= 1'b0;
		end else if (cyc_q) begin
			if (bus.ack) begin
				cyc_q      <= 1'b0;
				next_valid <= 1'b1;
			end
		end else if (adv) begin
			next_valid <= 1'b0;   // Next slot moves into current
		end else if (!next_valid && coming_ok) begin
			cyc_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_25_2m) begin
		if (!cyc_q)
			adr_q <= {front_sel, tile_idx};   // Frozen once the read is open
		if (cyc_q && bus.ack)
			next_word <= bus.dat_r;
		if (adv)
			cur_word <= next_word;
	end

	assign bus.cyc   = cyc_q;
	assign bus.stb   = cyc_q;
	assign bus.we    = 1'b0;   // Read only
	assign bus.adr   = adr_q;
	assign bus.dat_w = '0;

	// ====================
	// Output registers
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			pix <= '0;
			de  <= 1'b0;
			hs  <= 1'b1;   // Syncs idle high
			vs  <= 1'b1;
		end else begin
			pix <= raster.de ? cur_word : '0;   // Black outside active video
			de  <= raster.de;
			hs  <= raster.hs;
			vs  <= raster.vs;
		end
	end

endmodule

`default_nettype wire

// File: design/pattern_writer.sv
`default_nettype none

module pattern_writer import fb_pkg::*; (
	input  logic    clk_25_2m,
	input  logic    reset,
	raster_if.sink  raster,
	wb_if.master    bus,
	output logic    front_sel
);

	logic      cyc_q;       // Write outstanding
	logic      fill_done;   // Back buffer complete
	logic      parity;      // Pattern phase of the current fill
	logic      row_odd;     // Tile row parity
	coord_t    tx;          // Tile column
	tile_idx_t idx;         // Tile index, row by row
	logic      last_tile;

	assign last_tile = (idx == tile_idx_t'(tiles_per_frame - 1));

	// ====================
	// Fill and swap
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			front_sel <= 1'b0;   // Show buffer 0, fill buffer 1
			parity    <= 1'b0;
			fill_done <= 1'b0;
			cyc_q     <= 1'b0;
			tx        <= '0;
			row_odd   <= 1'b0;
			idx       <= '0;
		end else if (raster.vblank_start && fill_done) begin
			front_sel <= ~front_sel;   // Back buffer goes on screen
			parity    <= ~parity;
			fill_done <= 1'b0;
			tx        <= '0;
			row_odd   <= 1'b0;
			idx       <= '0;
		end else if (cyc_q) begin
			if (bus.ack) begin
				cyc_q <= 1'b0;   // Idle one clock so the display can get in
				idx   <= idx + 1'b1;
				if (last_tile)
					fill_done <= 1'b1;
				if (tx == coord_t'(tiles_x - 1)) begin
					tx      <= '0;
					row_odd <= ~row_odd;
				end else begin
					tx <= tx + 1'b1;
				end
			end
		end else if (!fill_done) begin
			cyc_q <= 1'b1;
		end
	end

	// Request fields only move on ack, so they stay stable for the bus
	assign bus.cyc   = cyc_q;
	assign bus.stb   = cyc_q;
	assign bus.we    = 1'b1;
	assign bus.adr   = {~front_sel, idx};   // Always the back buffer
	assign bus.dat_w = (tx[0] ^ row_odd ^ parity) ? color_blue : color_red;

endmodule

`default_nettype wire

// File: design/video_timing.sv
`default_nettype none

module video_timing import fb_pkg::*; (
	input  logic     clk_25_2m,
	input  logic     reset,
	raster_if.source raster
);

	coord_t h_cnt;   // Pixel within line
	coord_t v_cnt;   // Line within frame

	// ====================
	// Counters
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			h_cnt <= '0;   // Start on the first active pixel
			v_cnt <= '0;
		end else if (h_cnt == coord_t'(h_total - 1)) begin
			h_cnt <= '0;
			if (v_cnt == coord_t'(v_total - 1))
				v_cnt <= '0;   // Next frame
			else
				v_cnt <= v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// ====================
	// Decodes, no latency
	// ====================
	assign raster.x  = h_cnt;
	assign raster.y  = v_cnt;
	assign raster.de = (h_cnt < coord_t'(h_active)) && (v_cnt < coord_t'(v_active));

	// Sync pulses sit between front and back porch
	assign raster.hs = !((h_cnt >= coord_t'(h_active + h_front)) &&
		(h_cnt < coord_t'(h_total - h_back)));
	assign raster.vs = !((v_cnt >= coord_t'(v_active + v_front)) &&
		(v_cnt < coord_t'(v_total - v_back)));

	// Single clock at the top of vertical blank, used for the buffer swap
	assign raster.vblank_start = (h_cnt == '0) && (v_cnt == coord_t'(v_active));

endmodule

`default_nettype wire

// File: design/fb_ifs.sv
`default_nettype none

// ====================
// Wishbone classic
// ====================
interface wb_if import fb_pkg::*; ();
	logic     cyc;      // Bus cycle in progress
	logic     stb;      // Valid transfer
	logic     we;       // 1 = write
	wb_addr_t adr;
	pixel_t   dat_w;    // Master to slave
	pixel_t   dat_r;    // Slave to master
	logic     ack;      // One cycle per transfer

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);
endinterface

// ====================
// Raster position
// ====================
interface raster_if import fb_pkg::*; ();
	coord_t x;              // Current column
	coord_t y;              // Current line
	logic   de;             // Inside the 640x480 window
	logic   hs;             // Active low
	logic   vs;             // Active low
	logic   vblank_start;   // First clock of line 480

	modport source (output x, y, de, hs, vs, vblank_start);
	modport sink   (input x, y, de, hs, vs, vblank_start);
endinterface

`default_nettype wire

// File: design/fb_pkg.sv
`default_nettype none

package fb_pkg;

	// ====================
	// Pixel and bus types
	// ====================
	typedef logic [23:0] pixel_t;     // 8:8:8 RGB
	typedef logic [13:0] wb_addr_t;   // Bit 13 picks the buffer
	typedef logic [11:0] coord_t;     // Raster x or y

	localparam int tile_idx_w = 13;   // Tile index inside one buffer
	typedef logic [tile_idx_w-1:0] tile_idx_t;

	// ====================
	// 640x480 at 60 Hz
	// ====================
	localparam int h_active = 640;
	localparam int h_front  = 16;
	localparam int h_sync   = 96;     // hs low for this many clocks
	localparam int h_back   = 48;
	localparam int h_total  = 800;

	localparam int v_active = 480;
	localparam int v_front  = 10;
	localparam int v_sync   = 2;      // vs low for this many lines
	localparam int v_back   = 33;
	localparam int v_total  = 525;

	// Stored frame is one word per 8x8 screen block
	localparam int tile_shift      = 3;
	localparam int tiles_x         = 80;
	localparam int tiles_y         = 60;
	localparam int tiles_per_frame = 4800;
	localparam int ram_depth       = 1 << 14;   // Two buffers on a 13-bit index

	localparam pixel_t color_red  = 24'hFF0000;
	localparam pixel_t color_blue = 24'h0000FF;

endpackage

`default_nettype wire
